// File: cpuCore.f
hw/cpuPkg.sv
hw/cpuController.sv
hw/fetchUnit.sv
hw/decodeUnit.sv
hw/regFile.sv
hw/loadStoreUnit.sv
hw/cpuCore.sv
tests/cpuController_sva.sv
tests/cpuCoreChecker.sv
tests/cpuCoreTb.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --top-module cpuCoreTb -f cpuCore.f -o cpuCoreSim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/cpuCoreSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$logFile"; then
    exit 1
fi
exit 0

// File: tests/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

    localparam cpuPkg::word_t resetPc = 32'h0000_0100;
    localparam int progLen = 64;
    localparam int dataWords = 16;
    // worst case per instruction is 8 + 2 + 8 + 1 cycles
    localparam int cycleLimit = progLen * 19 + 200;
    localparam cpuPkg::word_t nopInstr = 32'h0000_0013;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic iReq;
    logic dReq;
    logic dWrite;
    logic iValid = 1'b0;
    logic dValid = 1'b0;
    logic done = 1'b0;
    logic reportReady;
    logic dPendWrite = 1'b0;

    cpuPkg::word_t iAddr;
    cpuPkg::word_t dAddr;
    cpuPkg::word_t dWData;
    cpuPkg::word_t iData = '0;
    cpuPkg::word_t dRData = '0;
    cpuPkg::word_t iPendAddr = '0;
    cpuPkg::word_t dPendAddr = '0;
    cpuPkg::word_t dPendData = '0;

    cpuPkg::word_t prog [progLen];
    cpuPkg::word_t dataInit [dataWords];
    cpuPkg::word_t dataMem [dataWords];

    logic [31:0] progState = 32'd25;
    logic [31:0] latState = 32'd25;
    int fetchCount = 0;
    int cycleCount = 0;
    int iWait = 0;
    int dWait = 0;
    int passCount;
    int failCount;

    cpuCore #(
        .resetPc (resetPc)
    ) i_cpuCore (
        .clk    (clk),
        .rst    (rst),
        .iReq   (iReq),
        .iAddr  (iAddr),
        .iData  (iData),
        .iValid (iValid),
        .dReq   (dReq),
        .dWrite (dWrite),
        .dAddr  (dAddr),
        .dWData (dWData),
        .dRData (dRData),
        .dValid (dValid)
    );

    cpuCoreChecker #(
        .resetPc   (resetPc),
        .progLen   (progLen),
        .dataWords (dataWords)
    ) i_cpuCoreChecker (
        .clk         (clk),
        .rst         (rst),
        .iReq        (iReq),
        .iAddr       (iAddr),
        .dReq        (dReq),
        .dWrite      (dWrite),
        .dAddr       (dAddr),
        .dWData      (dWData),
        .prog        (prog),
        .dataInit    (dataInit),
        .done        (done),
        .passCount   (passCount),
        .failCount   (failCount),
        .reportReady (reportReady)
    );

    // LCG step with the result taken from the upper half of the state
    function automatic logic [31:0] pickRandom(inout logic [31:0] state,
                                               input logic [31:0] range);
        state = state * 32'd1103515245 + 32'd12345;
        return {16'd0, state[31:16]} % range;
    endfunction

    task automatic buildProgram();
        logic [31:0] kind;
        logic [31:0] r;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [11:0] off;
        cpuPkg::word_t imm;
        cpuPkg::regIdx_t rd;
        cpuPkg::regIdx_t rs1;
        cpuPkg::regIdx_t rs2;
        for (int n = 0; n < progLen; n++) begin
            kind = pickRandom(progState, 32'd5);
            r = pickRandom(progState, 32'd8);
            rd = r[4:0];
            r = pickRandom(progState, 32'd8);
            rs1 = r[4:0];
            r = pickRandom(progState, 32'd8);
            rs2 = r[4:0];
            r = pickRandom(progState, 32'd16);
            off = {6'd0, r[3:0], 2'b00};
            hi = pickRandom(progState, 32'd65536);
            lo = pickRandom(progState, 32'd65536);
            imm = {hi[15:0], lo[15:0]};
            // loads and stores are always based on x0
            case (kind)
                32'd0: prog[n] = {imm[19:0], rd, cpuPkg::opcodeLui};
                32'd1: prog[n] = {imm[11:0], rs1, 3'b000, rd, cpuPkg::opcodeOpImm};
                32'd2: prog[n] = {7'd0, rs2, rs1, 3'b000, rd, cpuPkg::opcodeOp};
                32'd3: prog[n] = {off, 5'd0, 3'b010, rd, cpuPkg::opcodeLoad};
                default: prog[n] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], cpuPkg::opcodeStore};
            endcase
        end
        for (int i = 0; i < dataWords; i++) begin
            hi = pickRandom(progState, 32'd65536);
            lo = pickRandom(progState, 32'd65536);
            dataInit[i] = {hi[15:0], lo[15:0]};
        end
    endtask

    function automatic cpuPkg::word_t fetchWord(input cpuPkg::word_t addr);
        cpuPkg::word_t slot;
        slot = (addr - resetPc) >> 2;
        if (slot < 32'(progLen)) begin
            return prog[slot[5:0]];
        end
        return nopInstr;
    endfunction

    initial begin
        forever #5 clk = ~clk;
    end

    // both memories reply 1 to 8 cycles after the request
    always @(negedge clk) begin : memModel
        logic [31:0] r;
        iValid <= 1'b0;
        dValid <= 1'b0;
        if (rst) begin
            for (int i = 0; i < dataWords; i++) begin
                dataMem[i] = dataInit[i];
            end
        end else begin
            if (iWait > 0) begin
                iWait = iWait - 1;
                if (iWait == 0) begin
                    iValid <= 1'b1;
                    iData <= fetchWord(iPendAddr);
                end
            end
            if (dWait > 0) begin
                dWait = dWait - 1;
                if (dWait == 0) begin
                    dValid <= 1'b1;
                    if (dPendWrite) begin
                        dataMem[dPendAddr[5:2]] = dPendData;
                    end else begin
                        dRData <= dataMem[dPendAddr[5:2]];
                    end
                end
            end
            if (iReq) begin
                r = pickRandom(latState, 32'd8);
                iWait = int'(r) + 1;
                iPendAddr = iAddr;
                fetchCount = fetchCount + 1;
            end
            if (dReq) begin
                r = pickRandom(latState, 32'd8);
                dWait = int'(r) + 1;
                dPendAddr = dAddr;
                dPendData = dWData;
                dPendWrite = dWrite;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!done && cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, %0d of %0d instructions fetched",
                     cycleCount, fetchCount, progLen);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        buildProgram();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // the fetch after the last instruction means all of them retired
        wait (fetchCount > progLen);
        @(negedge clk);
        done = 1'b1;
        wait (reportReady);
        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/cpuCoreChecker.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreChecker #(
    parameter cpuPkg::word_t resetPc = '0,
    parameter int progLen = 64,
    parameter int dataWords = 16
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           iReq,
    input  cpuPkg::word_t iAddr,
    input  wire           dReq,
    input  wire           dWrite,
    input  cpuPkg::word_t dAddr,
    input  cpuPkg::word_t dWData,
    input  cpuPkg::word_t prog [progLen],
    input  cpuPkg::word_t dataInit [dataWords],
    input  wire           done,
    output int            passCount,
    output int            failCount,
    output logic          reportReady
);

    cpuPkg::word_t expFetch [$];
    cpuPkg::word_t expAddr [$];
    cpuPkg::word_t expData [$];
    logic expWrite [$];

    int expStores = 0;
    int fetchSeen = 0;
    int accessSeen = 0;
    int storesSeen = 0;
    int resetErrors = 0;
    int fetchErrors = 0;
    int dataErrors = 0;
    int countErrors = 0;
    logic modelBuilt = 1'b0;

    // ISA model of the program, one instruction at a time
    function automatic void buildExpected();
        cpuPkg::word_t regs [32];
        cpuPkg::word_t mem [dataWords];
        cpuPkg::word_t ins;
        cpuPkg::word_t immI;
        cpuPkg::word_t immS;
        cpuPkg::word_t ea;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < dataWords; i++) begin
            mem[i] = dataInit[i];
        end
        for (int n = 0; n <= progLen; n++) begin
            expFetch.push_back(resetPc + (32'(n) << 2));
        end
        for (int n = 0; n < progLen; n++) begin
            ins = prog[n];
            immI = {{20{ins[31]}}, ins[31:20]};
            immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            case (ins[6:0])
                cpuPkg::opcodeLui: regs[ins[11:7]] = {ins[31:12], 12'd0};
                cpuPkg::opcodeOpImm: regs[ins[11:7]] = regs[ins[19:15]] + immI;
                cpuPkg::opcodeOp: regs[ins[11:7]] = regs[ins[19:15]] + regs[ins[24:20]];
                cpuPkg::opcodeLoad: begin
                    ea = regs[ins[19:15]] + immI;
                    expAddr.push_back(ea);
                    expWrite.push_back(1'b0);
                    expData.push_back('0);
                    regs[ins[11:7]] = mem[ea[5:2]];
                end
                cpuPkg::opcodeStore: begin
                    ea = regs[ins[19:15]] + immS;
                    expAddr.push_back(ea);
                    expWrite.push_back(1'b1);
                    expData.push_back(regs[ins[24:20]]);
                    mem[ea[5:2]] = regs[ins[24:20]];
                    expStores++;
                end
                default: ;
            endcase
            regs[0] = '0;
        end
    endfunction

    function automatic int testFailed(input string name, input int errors);
        if (errors == 0) begin
            $display("test %s: pass", name);
            return 0;
        end
        $display("test %s: fail with %0d errors", name, errors);
        return 1;
    endfunction

    always @(posedge clk) begin : compare
        int failed;
        if (rst) begin
            reportReady <= 1'b0;
            if (iReq || dReq) begin
                resetErrors++;
                $display("[ERROR] %0t: request pulse while reset is asserted", $time);
            end
        end else begin
            if (!modelBuilt) begin
                buildExpected();
                modelBuilt = 1'b1;
            end
            if (iReq) begin
                if (fetchSeen < expFetch.size() && iAddr !== expFetch[fetchSeen]) begin
                    $display("[ERROR] %0t: fetch %0d at address %h, expected %h",
                             $time, fetchSeen, iAddr, expFetch[fetchSeen]);
                    if (fetchSeen == 0) begin
                        resetErrors++;
                    end else begin
                        fetchErrors++;
                    end
                end
                fetchSeen++;
            end
            if (dReq) begin
                if (accessSeen >= expAddr.size()) begin
                    $display("unexpected data access number %0d to address %h", accessSeen, dAddr);
                    dataErrors++;
                end else if (dAddr !== expAddr[accessSeen] || dWrite !== expWrite[accessSeen]
                             || (dWrite && dWData !== expData[accessSeen])) begin
                    $display("[ERROR] %0t: access %0d write %b addr %h data %h, expected %b %h %h",
                             $time, accessSeen, dWrite, dAddr, dWData, expWrite[accessSeen],
                             expAddr[accessSeen], expData[accessSeen]);
                    dataErrors++;
                end
                if (dWrite) begin
                    storesSeen++;
                end
                accessSeen++;
            end
            if (done && !reportReady) begin
                if (storesSeen != expStores || accessSeen != expAddr.size()) begin
                    $display("store count mismatch: %0d stores in %0d accesses, expected %0d in %0d",
                             storesSeen, accessSeen, expStores, expAddr.size());
                    countErrors++;
                end
                failed = testFailed("reset and first fetch", resetErrors);
                failed += testFailed("sequential fetch", fetchErrors);
                failed += testFailed("data access sequence", dataErrors);
                failed += testFailed("store count", countErrors);
                passCount <= 4 - failed;
                failCount <= failed;
                reportReady <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/cpuController_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpuControllerSva (
    input wire clk,
    input wire rst,
    input wire iReq,
    input wire dReq,
    input wire iValid,
    input wire dValid
);

    // high from the cycle after a request until its reply
    logic waiting;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            waiting <= 1'b0;
        end else if (iReq || dReq) begin
            waiting <= 1'b1;
        end else if (iValid || dValid) begin
            waiting <= 1'b0;
        end
    end

    reqExclusive: assert property (@(posedge clk) disable iff (rst) !(iReq && dReq))
        else $error("iReq and dReq asserted in the same cycle");

    iReqPulse: assert property (@(posedge clk) disable iff (rst) iReq |=> !iReq)
        else $error("iReq held for more than one cycle");

    dReqPulse: assert property (@(posedge clk) disable iff (rst) dReq |=> !dReq)
        else $error("dReq held for more than one cycle");

    singleOutstanding: assert property (@(posedge clk) disable iff (rst)
        waiting |-> !(iReq || dReq))
        else $error("new request issued before the previous reply");

endmodule

bind cpuController cpuControllerSva i_cpuControllerSva (
    .clk    (clk),
    .rst    (rst),
    .iReq   (iReq),
    .dReq   (dReq),
    .iValid (iValid),
    .dValid (dValid)
);

`default_nettype wire

// File: hw/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
    parameter cpuPkg::word_t resetPc = '0
) (
    input  wire           clk,
    input  wire           rst,
    output logic          iReq,
    output cpuPkg::word_t iAddr,
    input  cpuPkg::word_t iData,
    input  wire           iValid,
    output logic          dReq,
    output logic          dWrite,
    output cpuPkg::word_t dAddr,
    output cpuPkg::word_t dWData,
    input  cpuPkg::word_t dRData,
    input  wire           dValid
);

    logic retire;
    logic fetchEnd;
    logic isMem;
    logic isStore;
    logic rdWriteEn;

    cpuPkg::word_t instr;
    cpuPkg::word_t rs1Data;
    cpuPkg::word_t rs2Data;
    cpuPkg::word_t loadData;
    cpuPkg::word_t memAddr;
    cpuPkg::word_t wbData;
    cpuPkg::word_t storeData;

    cpuPkg::regIdx_t rs1Idx;
    cpuPkg::regIdx_t rs2Idx;
    cpuPkg::regIdx_t rdIdx;

    cpuController i_cpuController (
        .clk      (clk),
        .rst      (rst),
        .iValid   (iValid),
        .dValid   (dValid),
        .isMem    (isMem),
        .iReq     (iReq),
        .dReq     (dReq),
        .retire   (retire),
        .fetchEnd (fetchEnd)
    );

    fetchUnit #(
        .resetPc (resetPc)
    ) i_fetchUnit (
        .clk      (clk),
        .rst      (rst),
        .fetchEnd (fetchEnd),
        .iData    (iData),
        .retire   (retire),
        .pc       (iAddr),
        .instr    (instr)
    );

    decodeUnit i_decodeUnit (
        .instr     (instr),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .loadData  (loadData),
        .rs1Idx    (rs1Idx),
        .rs2Idx    (rs2Idx),
        .rdIdx     (rdIdx),
        .rdWriteEn (rdWriteEn),
        .isMem     (isMem),
        .isStore   (isStore),
        .memAddr   (memAddr),
        .wbData    (wbData),
        .storeData (storeData)
    );

    regFile i_regFile (
        .clk       (clk),
        .rst       (rst),
        .rs1Idx    (rs1Idx),
        .rs2Idx    (rs2Idx),
        .rdIdx     (rdIdx),
        .rdWriteEn (rdWriteEn),
        .retire    (retire),
        .wbData    (wbData),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    loadStoreUnit i_loadStoreUnit (
        .clk       (clk),
        .rst       (rst),
        .retire    (retire),
        .dReq      (dReq),
        .memAddr   (memAddr),
        .storeData (storeData),
        .isStore   (isStore),
        .dRData    (dRData),
        .dAddr     (dAddr),
        .dWData    (dWData),
        .dWrite    (dWrite),
        .loadData  (loadData)
    );

endmodule

`default_nettype wire

// File: hw/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit (
    input  wire           clk,
    input  wire           rst,
    input  wire           retire,
    input  wire           dReq,
    input  cpuPkg::word_t memAddr,
    input  cpuPkg::word_t storeData,
    input  wire           isStore,
    input  cpuPkg::word_t dRData,
    output cpuPkg::word_t dAddr,
    output cpuPkg::word_t dWData,
    output logic          dWrite,
    output cpuPkg::word_t loadData
);

    logic writeQ;

    cpuPkg::word_t addrQ;
    cpuPkg::word_t dataQ;

    // direction of the access in flight until the instruction retires
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            writeQ <= 1'b0;
        end else if (dReq) begin
            writeQ <= isStore;
        end else if (retire) begin
            writeQ <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dReq) begin
            addrQ <= memAddr;
            dataQ <= storeData;
        end
    end

    // decoded values in the request cycle and the held copies after it
    assign dAddr = dReq ? memAddr : addrQ;
    assign dWData = dReq ? storeData : dataQ;
    assign dWrite = dReq ? isStore : writeQ;

    assign loadData = dRData;

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire             clk,
    input  wire             rst,
    input  cpuPkg::regIdx_t rs1Idx,
    input  cpuPkg::regIdx_t rs2Idx,
    input  cpuPkg::regIdx_t rdIdx,
    input  wire             rdWriteEn,
    input  wire             retire,
    input  cpuPkg::word_t   wbData,
    output cpuPkg::word_t   rs1Data,
    output cpuPkg::word_t   rs2Data
);

    cpuPkg::word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (retire && rdWriteEn && (rdIdx != '0)) begin
            regs[rdIdx] <= wbData;
        end
    end

    // x0 always reads as zero
    assign rs1Data = (rs1Idx == '0) ? '0 : regs[rs1Idx];
    assign rs2Data = (rs2Idx == '0) ? '0 : regs[rs2Idx];

endmodule

`default_nettype wire

// File: hw/decodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module decodeUnit (
    input  cpuPkg::word_t   instr,
    input  cpuPkg::word_t   rs1Data,
    input  cpuPkg::word_t   rs2Data,
    input  cpuPkg::word_t   loadData,
    output cpuPkg::regIdx_t rs1Idx,
    output cpuPkg::regIdx_t rs2Idx,
    output cpuPkg::regIdx_t rdIdx,
    output logic            rdWriteEn,
    output logic            isMem,
    output logic            isStore,
    output cpuPkg::word_t   memAddr,
    output cpuPkg::word_t   wbData,
    output cpuPkg::word_t   storeData
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    cpuPkg::word_t immI;
    cpuPkg::word_t immS;
    cpuPkg::word_t immU;
    cpuPkg::word_t aluResult;

    logic isLui;
    logic isAddi;
    logic isAdd;
    logic isLoad;

    assign opcode = instr[6:0];
    assign rdIdx = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1Idx = instr[19:15];
    assign rs2Idx = instr[24:20];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immU = {instr[31:12], 12'b0};

    // only word accesses and plain adds, anything else is a no-op
    assign isLui = (opcode == cpuPkg::opcodeLui);
    assign isAddi = (opcode == cpuPkg::opcodeOpImm) && (funct3 == 3'b000);
    assign isAdd = (opcode == cpuPkg::opcodeOp) && (funct3 == 3'b000) && (funct7 == 7'b0);
    assign isLoad = (opcode == cpuPkg::opcodeLoad) && (funct3 == 3'b010);
    assign isStore = (opcode == cpuPkg::opcodeStore) && (funct3 == 3'b010);
    assign isMem = isLoad || isStore;

    always_comb begin
        aluResult = '0;
        if (isLui) begin
            aluResult = immU;
        end else if (isAddi) begin
            aluResult = rs1Data + immI;
        end else if (isAdd) begin
            aluResult = rs1Data + rs2Data;
        end
    end

    // effective address, S-type offset for stores
    assign memAddr = rs1Data + (isStore ? immS : immI);
    assign storeData = rs2Data;

    assign wbData = isLoad ? loadData : aluResult;
    assign rdWriteEn = (isLui || isAddi || isAdd || isLoad) && (rdIdx != '0);

endmodule

`default_nettype wire

// File: hw/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
    parameter cpuPkg::word_t resetPc = '0
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           fetchEnd,
    input  cpuPkg::word_t iData,
    input  wire           retire,
    output cpuPkg::word_t pc,
    output cpuPkg::word_t instr
);

    localparam cpuPkg::word_t pcStep = 32'd4;

    // no control flow, so the pc only ever steps forward
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= resetPc;
        end else if (retire) begin
            pc <= pc + pcStep;
        end
    end

    // instruction register, stable from decode until the next fetch reply
    always_ff @(posedge clk) begin
        if (fetchEnd) begin
            instr <= iData;
        end
    end

endmodule

`default_nettype wire

// File: hw/cpuController.sv
`timescale 1ns/1ps
`default_nettype none

module cpuController (
    input  wire  clk,
    input  wire  rst,
    input  wire  iValid,
    input  wire  dValid,
    input  wire  isMem,
    output logic iReq,
    output logic dReq,
    output logic retire,
    output logic fetchEnd
);

    cpuPkg::ctrlState_t state;
    cpuPkg::ctrlState_t nextState;

    // set once the request for the current access has gone out
    logic iPending;
    logic dPending;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cpuPkg::stInit;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::stInit: begin
                nextState = cpuPkg::stFetch;
            end
            cpuPkg::stFetch: begin
                if (iValid) begin
                    nextState = cpuPkg::stDecode;
                end
            end
            cpuPkg::stDecode: begin
                if (isMem) begin
                    nextState = cpuPkg::stMem;
                end else begin
                    nextState = cpuPkg::stFetch;
                end
            end
            cpuPkg::stMem: begin
                if (dValid) begin
                    nextState = cpuPkg::stFetch;
                end
            end
            default: begin
                nextState = cpuPkg::stInit;
            end
        endcase
    end

    // request pulses follow the state being entered, one per access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iReq <= 1'b0;
            dReq <= 1'b0;
            iPending <= 1'b0;
            dPending <= 1'b0;
        end else begin
            if (nextState == cpuPkg::stFetch) begin
                iReq <= ~iPending;
                iPending <= 1'b1;
            end else begin
                iReq <= 1'b0;
                iPending <= 1'b0;
            end
            if (nextState == cpuPkg::stMem) begin
                dReq <= ~dPending;
                dPending <= 1'b1;
            end else begin
                dReq <= 1'b0;
                dPending <= 1'b0;
            end
        end
    end

    assign fetchEnd = iValid && (state == cpuPkg::stFetch);

    // non-memory ops finish in decode, loads and stores on the data reply
    assign retire = ((state == cpuPkg::stDecode) && !isMem)
                 || ((state == cpuPkg::stMem) && dValid);

endmodule

`default_nettype wire

// File: hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int wordWidth = 32;
    localparam int regIdxWidth = 5;
    localparam int opcodeWidth = 7;

    // data, address and instruction words
    typedef logic [wordWidth-1:0] word_t;
    typedef logic [regIdxWidth-1:0] regIdx_t;

    // RV32I major opcodes handled by the core
    localparam logic [opcodeWidth-1:0] opcodeLui = 7'b0110111;
    localparam logic [opcodeWidth-1:0] opcodeOpImm = 7'b0010011;
    localparam logic [opcodeWidth-1:0] opcodeOp = 7'b0110011;
    localparam logic [opcodeWidth-1:0] opcodeLoad = 7'b0000011;
    localparam logic [opcodeWidth-1:0] opcodeStore = 7'b0100011;

    // sequencer phases
    typedef enum logic [1:0] {
        stInit,
        stFetch,
        stDecode,
        stMem
    } ctrlState_t;

endpackage

`default_nettype wire
